// ==== src/modemPkg.sv ====
`default_nettype none

package modemPkg;

	////////////////////////////////////////
	// Data path widths
	////////////////////////////////////////
	parameter int DATA_WIDTH   = 4;	// One nibble per FIFO word
	parameter int SYMBOL_WIDTH = 2;	// Bits per QPSK symbol
	parameter int GAIN_WIDTH   = 4;	// Amplitude control at the top

	// Signed sample width
	// 15 * 1.65 * sqrt(2) still fits after CORDIC growth
	parameter int IQ_WIDTH     = 8;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////
	typedef logic [DATA_WIDTH-1:0] nibble_t;	// Payload of both FIFOs

	// One QPSK symbol
	// High bit selects a negative I
	// Low bit selects a negative Q
	typedef logic [SYMBOL_WIDTH-1:0] dibit_t;

endpackage

`default_nettype wire

// ==== src/cordicPkg.sv ====
`default_nettype none

package cordicPkg;

	////////////////////////////////////////
	// Angle format
	////////////////////////////////////////
	// Unsigned fraction of a full turn
	// Zero lies on the positive I axis and angles grow counterclockwise
	parameter int ANGLE_WIDTH = 12;

	typedef logic [ANGLE_WIDTH-1:0] angle_t;

	parameter angle_t quarterTurn = angle_t'(1 << (ANGLE_WIDTH - 2));
	parameter angle_t halfTurn    = angle_t'(1 << (ANGLE_WIDTH - 1));

	////////////////////////////////////////
	// Arctangent per stage
	////////////////////////////////////////
	parameter int ATAN_STAGES = 12;	// Longest pipeline supported

	// atan(2^-i) in units of 1/4096 turn
	parameter angle_t atanTable [ATAN_STAGES] = '{
		12'd512,	// 45 degrees
		12'd302,
		12'd160,
		12'd81,
		12'd41,
		12'd20,
		12'd10,
		12'd5,
		12'd3,
		12'd1,
		12'd1,
		12'd0	// Below one LSB
	};

endpackage

`default_nettype wire

// ==== src/iqIf.sv ====
`default_nettype none

interface iqIf #(
	parameter int WIDTH = 8
) ();

	logic             valid;	// Word present
	logic             ready;	// Sink takes the word
	logic             last;	// Second dibit of a nibble
	logic [WIDTH-1:0] data0;	// I sample or angle
	logic [WIDTH-1:0] data1;	// Q sample

	modport source (
		output valid,
		output last,
		output data0,
		output data1,
		input  ready
	);

	modport sink (
		input  valid,
		input  last,
		input  data0,
		input  data1,
		output ready
	);

endinterface

`default_nettype wire

// ==== src/syncFifo.sv ====
`default_nettype none

module syncFifo #(
	parameter int WIDTH = 4,
	parameter int DEPTH = 8
) (
	input  logic             inClock,
	input  logic             reset,
	input  logic             writeEnable,
	input  logic [WIDTH-1:0] writeData,
	output logic             full,
	input  logic             readEnable,
	output logic [WIDTH-1:0] readData,
	output logic             empty
);

	localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]       mem [DEPTH];
	logic [PTR_WIDTH-1:0]   writePtr;
	logic [PTR_WIDTH-1:0]   readPtr;
	logic [COUNT_WIDTH-1:0] count;	// Words stored
	logic                   push;
	logic                   pop;

	// Wraps at DEPTH, so DEPTH need not be a power of two
	function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
		return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign push     = writeEnable && !full;	// Write while full is dropped
	assign pop      = readEnable && !empty;	// Read while empty is ignored
	assign full     = (count == COUNT_WIDTH'(DEPTH));
	assign empty    = (count == '0);
	assign readData = mem[readPtr];	// Head always on the output

	always_ff @(posedge inClock) begin
		if (reset) begin
			writePtr <= '0;
			readPtr  <= '0;
			count    <= '0;
		end else begin
			if (push) begin
				writePtr <= nextPtr(writePtr);
			end
			if (pop) begin
				readPtr <= nextPtr(readPtr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	always_ff @(posedge inClock) begin
		if (push) begin
			mem[writePtr] <= writeData;
		end
	end

endmodule

`default_nettype wire

// ==== src/qpskMapper.sv ====
`default_nettype none

module qpskMapper import modemPkg::*; #(
	parameter int IQ_WIDTH = modemPkg::IQ_WIDTH
) (
	input  logic                  inClock,
	input  logic                  reset,
	input  nibble_t               fifoData,
	input  logic                  fifoEmpty,
	output logic                  fifoRead,
	input  logic [GAIN_WIDTH-1:0] gain,
	iqIf.source                   iq
);

	typedef enum logic {
		selHigh,	// Waiting for a nibble
		selLow	// Low dibit still to send
	} mapState_t;

	mapState_t           state;
	logic                regFree;	// Output register empty or being taken
	logic                loadLow;
	dibit_t              highDibit;
	dibit_t              lowDibit;	// Held while the high point waits
	logic [IQ_WIDTH-1:0] gainNow;
	logic [IQ_WIDTH-1:0] gainReg;	// Amplitude sampled at the pop
	logic                outValid;
	logic                outLast;
	logic [IQ_WIDTH-1:0] outI;
	logic [IQ_WIDTH-1:0] outQ;

	function automatic logic [IQ_WIDTH-1:0] scale(
		input logic                negative,
		input logic [IQ_WIDTH-1:0] magnitude
	);
		return negative ? -magnitude : magnitude;
	endfunction

	assign highDibit = fifoData[DATA_WIDTH-1 -: SYMBOL_WIDTH];
	assign gainNow   = IQ_WIDTH'(gain);
	assign regFree   = !outValid || iq.ready;
	assign fifoRead  = (state == selHigh) && !fifoEmpty && regFree;
	assign loadLow   = (state == selLow) && regFree;

	always_ff @(posedge inClock) begin
		if (reset) begin
			state    <= selHigh;
			outValid <= 1'b0;
		end else if (fifoRead) begin
			state    <= selLow;
			outValid <= 1'b1;
		end else if (loadLow) begin
			state    <= selHigh;
			outValid <= 1'b1;
		end else if (iq.ready) begin
			outValid <= 1'b0;	// Word taken, nothing new
		end
	end

	always_ff @(posedge inClock) begin
		if (fifoRead) begin
			outI     <= scale(highDibit[1], gainNow);
			outQ     <= scale(highDibit[0], gainNow);
			outLast  <= 1'b0;
			lowDibit <= fifoData[SYMBOL_WIDTH-1:0];
			gainReg  <= gainNow;
		end else if (loadLow) begin
			outI    <= scale(lowDibit[1], gainReg);
			outQ    <= scale(lowDibit[0], gainReg);
			outLast <= 1'b1;	// Closes the nibble
		end
	end

	assign iq.valid = outValid;
	assign iq.last  = outLast;
	assign iq.data0 = outI;
	assign iq.data1 = outQ;

endmodule

`default_nettype wire

// ==== src/cordicVectoring.sv ====
`default_nettype none

module cordicVectoring import cordicPkg::*; #(
	parameter int ITERATIONS = 10,	// At most ATAN_STAGES
	parameter int IQ_WIDTH   = modemPkg::IQ_WIDTH
) (
	input  logic inClock,
	input  logic reset,
	iqIf.sink    iq,
	iqIf.source  angle
);

	localparam int XY_WIDTH = IQ_WIDTH + 2;	// Headroom for the CORDIC gain

	// Index 0 is the pre-rotation register
	logic signed [XY_WIDTH-1:0] xStage [ITERATIONS+1];
	logic signed [XY_WIDTH-1:0] yStage [ITERATIONS+1];
	angle_t                     zStage [ITERATIONS+1];
	logic [ITERATIONS:0]        stageValid;
	logic [ITERATIONS:0]        stageLast;
	logic signed [XY_WIDTH-1:0] inI;
	logic signed [XY_WIDTH-1:0] inQ;
	logic                       advance;

	assign inI = XY_WIDTH'(signed'(iq.data0));
	assign inQ = XY_WIDTH'(signed'(iq.data1));

	// Whole pipeline holds while the result waits
	assign advance  = angle.ready || !stageValid[ITERATIONS];
	assign iq.ready = advance;

	////////////////////////////////////////
	// Valid chain
	////////////////////////////////////////
	always_ff @(posedge inClock) begin
		if (reset) begin
			stageValid <= '0;
		end else if (advance) begin
			stageValid <= {stageValid[ITERATIONS-1:0], iq.valid};
		end
	end

	////////////////////////////////////////
	// Rotation stages
	////////////////////////////////////////
	always_ff @(posedge inClock) begin
		if (advance) begin
			stageLast <= {stageLast[ITERATIONS-1:0], iq.last};

			// Left half plane folded by a half turn
			if (inI < 0) begin
				xStage[0] <= -inI;
				yStage[0] <= -inQ;
				zStage[0] <= halfTurn;
			end else begin
				xStage[0] <= inI;
				yStage[0] <= inQ;
				zStage[0] <= '0;
			end

			// Drive Q toward zero and sum the angles used
			for (int i = 0; i < ITERATIONS; i++) begin
				if (yStage[i] < 0) begin
					xStage[i+1] <= xStage[i] - (yStage[i] >>> i);
					yStage[i+1] <= yStage[i] + (xStage[i] >>> i);
					zStage[i+1] <= zStage[i] - atanTable[i];	// Wraps modulo a turn
				end else begin
					xStage[i+1] <= xStage[i] + (yStage[i] >>> i);
					yStage[i+1] <= yStage[i] - (xStage[i] >>> i);
					zStage[i+1] <= zStage[i] + atanTable[i];
				end
			end
		end
	end

	assign angle.valid = stageValid[ITERATIONS];
	assign angle.last  = stageLast[ITERATIONS];
	assign angle.data0 = zStage[ITERATIONS];
	assign angle.data1 = '0;	// No second word on this link

endmodule

`default_nettype wire

// ==== src/qpskSlicer.sv ====
`default_nettype none

module qpskSlicer import modemPkg::*, cordicPkg::*; (
	input  logic    inClock,
	input  logic    reset,
	iqIf.sink       angle,
	output nibble_t fifoData,
	output logic    fifoWrite,
	input  logic    fifoFull
);

	angle_t     angleWord;
	logic [1:0] quadrant;
	dibit_t     symbol;
	dibit_t     firstDibit;	// High dibit of the nibble in progress
	logic       take;

	// Quadrant order is Gray coded
	function automatic dibit_t quadrantToDibit(input logic [1:0] q);
		dibit_t d;
		case (q)
			2'd0:    d = 2'b00;
			2'd1:    d = 2'b10;
			2'd2:    d = 2'b11;
			default: d = 2'b01;
		endcase
		return d;
	endfunction

	assign angleWord = angle.data0;
	assign quadrant  = 2'(angleWord / quarterTurn);	// Top two angle bits
	assign symbol    = quadrantToDibit(quadrant);

	assign angle.ready = !fifoFull;
	assign take        = angle.valid && angle.ready;

	// Nibble goes out in the cycle of the second dibit
	assign fifoWrite = take && angle.last;
	assign fifoData  = {firstDibit, symbol};

	always_ff @(posedge inClock) begin
		if (reset) begin
			firstDibit <= '0;
		end else if (take && !angle.last) begin
			firstDibit <= symbol;
		end
	end

endmodule

`default_nettype wire

// ==== src/modemTop.sv ====
`default_nettype none

module modemTop import modemPkg::*, cordicPkg::*; #(
	parameter int IN_DEPTH   = 8,
	parameter int OUT_DEPTH  = 4,
	parameter int ITERATIONS = 10,
	parameter int IQ_WIDTH   = modemPkg::IQ_WIDTH
) (
	input  logic                  inClock,
	input  logic                  reset,
	input  nibble_t               inData,
	input  logic                  inWriteEnable,
	output logic                  inFull,
	input  logic [GAIN_WIDTH-1:0] inGain,
	output nibble_t               outData,
	input  logic                  outReadEnable,
	output logic                  outEmpty
);

	nibble_t inHead;	// FWFT head of the input FIFO
	logic    inEmpty;
	logic    inRead;
	nibble_t slicedData;
	logic    slicedWrite;
	logic    outFull;

	iqIf #(.WIDTH(IQ_WIDTH))    mapToCordic ();
	iqIf #(.WIDTH(ANGLE_WIDTH)) cordicToSlicer ();

	////////////////////////////////////////
	// Input side
	////////////////////////////////////////
	syncFifo #(
		.WIDTH (DATA_WIDTH),
		.DEPTH (IN_DEPTH)
	) inFifo (
		.inClock     (inClock),
		.reset       (reset),
		.writeEnable (inWriteEnable),
		.writeData   (inData),
		.full        (inFull),
		.readEnable  (inRead),
		.readData    (inHead),
		.empty       (inEmpty)
	);

	qpskMapper #(
		.IQ_WIDTH (IQ_WIDTH)
	) u_mapper (
		.inClock   (inClock),
		.reset     (reset),
		.fifoData  (inHead),
		.fifoEmpty (inEmpty),
		.fifoRead  (inRead),
		.gain      (inGain),
		.iq        (mapToCordic.source)
	);

	////////////////////////////////////////
	// Processing
	////////////////////////////////////////
	cordicVectoring #(
		.ITERATIONS (ITERATIONS),
		.IQ_WIDTH   (IQ_WIDTH)
	) u_cordic (
		.inClock (inClock),
		.reset   (reset),
		.iq      (mapToCordic.sink),
		.angle   (cordicToSlicer.source)
	);

	////////////////////////////////////////
	// Output side
	////////////////////////////////////////
	qpskSlicer u_slicer (
		.inClock   (inClock),
		.reset     (reset),
		.angle     (cordicToSlicer.sink),
		.fifoData  (slicedData),
		.fifoWrite (slicedWrite),
		.fifoFull  (outFull)	// Back-pressure starts here
	);

	syncFifo #(
		.WIDTH (DATA_WIDTH),
		.DEPTH (OUT_DEPTH)
	) outFifo (
		.inClock     (inClock),
		.reset       (reset),
		.writeEnable (slicedWrite),
		.writeData   (slicedData),
		.full        (outFull),
		.readEnable  (outReadEnable),
		.readData    (outData),
		.empty       (outEmpty)
	);

endmodule

`default_nettype wire

// ==== test/modemTop_props.sv ====
`default_nettype none

module modemTop_props #(
	parameter int WIDTH = 4
) (
	input logic             inClock,
	input logic             reset,
	input logic             push,	// Word entering the block
	input logic             full,	// Block cannot take a word
	input logic             valid,
	input logic             ready,
	input logic [WIDTH-1:0] data
);

	timeunit 1ns;
	timeprecision 1ps;

	noPushWhenFull: assert property (@(posedge inClock) disable iff (reset)
		push |-> !full)
		else $error("word stored while the block was full");

	// Source keeps its word until the sink takes it
	holdWhileStalled: assert property (@(posedge inClock) disable iff (reset)
		valid && !ready |=> valid && $stable(data))
		else $error("held word changed before it was taken");

	idleAfterReset: assert property (@(posedge inClock)
		reset |=> !valid)
		else $error("valid high in the cycle after reset");

endmodule

////////////////////////////////////////
// Attachments
////////////////////////////////////////
bind syncFifo modemTop_props #(.WIDTH(modemPkg::DATA_WIDTH)) u_fifoProps (
	.inClock (inClock),
	.reset   (reset),
	.push    (push),
	.full    (writePtr == readPtr && !empty),	// Full seen from the pointers
	.valid   (!empty),	// FWFT head counts as a held word
	.ready   (readEnable),
	.data    (readData)
);

bind cordicVectoring modemTop_props #(.WIDTH(2 * modemPkg::IQ_WIDTH)) u_iqProps (
	.inClock (inClock),
	.reset   (reset),
	.push    (iq.valid && iq.ready),
	.full    (&stageValid && !angle.ready),	// Every stage occupied, result waiting
	.valid   (iq.valid),
	.ready   (iq.ready),
	.data    ({iq.data0, iq.data1})
);

bind cordicVectoring modemTop_props #(.WIDTH(cordicPkg::ANGLE_WIDTH)) u_angleProps (
	.inClock (inClock),
	.reset   (reset),
	.push    (iq.valid && iq.ready),
	.full    (&stageValid && !angle.ready),
	.valid   (angle.valid),
	.ready   (angle.ready),
	.data    (angle.data0)
);

`default_nettype wire

// ==== test/tbModemTop.sv ====
`default_nettype none

module tbModemTop import modemPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT     = 2000;	// Cycles per wait loop
	localparam int QUIET       = 40;	// Longer than the whole chain

	logic                  inClock;
	logic                  reset;
	nibble_t               inData;
	logic                  inWriteEnable;
	logic                  inFull;
	logic [GAIN_WIDTH-1:0] inGain;
	nibble_t               outData;
	logic                  outReadEnable;
	logic                  outEmpty;

	nibble_t expected [$];	// Accepted nibbles not yet read
	integer  seed = 32'he041_ffc5;
	int      errors;
	int      checks;
	int      testsRun;
	int      testsFailed;

	modemTop #(
		.IN_DEPTH   (8),
		.OUT_DEPTH  (4),
		.ITERATIONS (10),
		.IQ_WIDTH   (8)
	) i_dut (
		.inClock       (inClock),
		.reset         (reset),
		.inData        (inData),
		.inWriteEnable (inWriteEnable),
		.inFull        (inFull),
		.inGain        (inGain),
		.outData       (outData),
		.outReadEnable (outReadEnable),
		.outEmpty      (outEmpty)
	);

	initial begin
		inClock = 1'b0;
		forever #10 inClock = ~inClock;
	end

	function automatic logic [GAIN_WIDTH-1:0] randomGain();
		return GAIN_WIDTH'(1 + ($unsigned($random(seed)) % 15));	// 1 to 15
	endfunction

	////////////////////////////////////////
	// One clock edge with model update
	////////////////////////////////////////
	task automatic step(input logic write, input logic read);
		nibble_t head;
		@(posedge inClock);
		if (inWriteEnable && !inFull) begin
			expected.push_back(inData);	// Stored at this edge
		end
		if (outReadEnable && !outEmpty) begin
			checks++;
			assert (expected.size() > 0) else begin
				$display("[ERROR] %0t: extra word %h at outData", $time, outData);
				errors++;
			end
			if (expected.size() > 0) begin
				head = expected.pop_front();
				assert (outData == head) else begin
					$display("[ERROR] %0t: outData %h, expected %h", $time, outData, head);
					errors++;
				end
			end
		end
		inWriteEnable <= write;
		inData        <= nibble_t'($random(seed));
		inGain        <= randomGain();
		outReadEnable <= read;
	endtask

	task automatic checkLevel(input logic actual, input logic want, input string what);
		checks++;
		assert (actual == want) else begin
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, actual, want);
			errors++;
		end
	endtask

	task automatic waitForOutput();
		int n;
		n = 0;
		while (outEmpty && n < TIMEOUT) begin
			step(1'b0, 1'b0);
			n++;
		end
		if (outEmpty) begin
			$display("Timeout: no nibble reached the output within %0d cycles", TIMEOUT);
			errors++;
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (expected.size() > 0 && n < TIMEOUT) begin
			step(1'b0, 1'b1);
			n++;
		end
		if (expected.size() > 0) begin
			$display("Timeout: %0d accepted nibbles never came out", expected.size());
			errors++;
		end
		for (n = 0; n < QUIET; n++) begin
			step(1'b0, 1'b1);	// Any late word fails here
		end
		checkLevel(outEmpty, 1'b1, "outEmpty after drain");
	endtask

	task automatic fillUntilFull();
		int n;
		int fullRun;
		n = 0;
		while (!inFull && n < TIMEOUT) begin
			step(1'b1, 1'b0);
			n++;
		end
		if (!inFull) begin
			$display("Timeout: inFull never rose with reads stopped");
			errors++;
		end
		n       = 0;
		fullRun = 0;
		while (fullRun < QUIET && n < TIMEOUT) begin
			step(1'b1, 1'b0);
			fullRun = inFull ? fullRun + 1 : 0;	// Stall has reached the input
			n++;
		end
		if (fullRun < QUIET) begin
			$display("Timeout: inFull kept dropping with reads stopped");
			errors++;
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testsRun++;
		if (errors == errorsBefore) begin
			$display("Test %0d %s: ok", testsRun, name);
		end else begin
			testsFailed++;
			$display("Test %0d %s: failed, %0d errors", testsRun, name, errors - errorsBefore);
		end
	endtask

	initial begin
		int mark;
		reset         = 1'b1;
		inData        = '0;
		inWriteEnable = 1'b0;
		inGain        = GAIN_WIDTH'(1);
		outReadEnable = 1'b0;
		errors        = 0;
		checks        = 0;
		testsRun      = 0;
		testsFailed   = 0;
		repeat (16) @(posedge inClock);
		reset <= 1'b0;

		mark = errors;
		step(1'b0, 1'b0);
		checkLevel(outEmpty, 1'b1, "outEmpty");
		checkLevel(inFull, 1'b0, "inFull");
		finishTest("reset state", mark);

		mark = errors;
		step(1'b1, 1'b0);	// One nibble, random gain
		waitForOutput();
		step(1'b0, 1'b1);
		step(1'b0, 1'b0);
		drain();
		finishTest("single nibble", mark);

		mark = errors;
		repeat (400) step(1'($random(seed)), 1'($random(seed)));
		drain();
		finishTest("random bursts", mark);

		mark = errors;
		fillUntilFull();
		drain();
		finishTest("back-pressure", mark);

		////////////////////////////////////////
		// Idle accesses
		////////////////////////////////////////
		mark = errors;
		repeat (20) begin
			step(1'b0, 1'b1);
			checkLevel(outEmpty, 1'b1, "outEmpty during empty reads");
		end
		fillUntilFull();
		repeat (20) begin
			step(1'b1, 1'b0);
			checkLevel(inFull, 1'b1, "inFull during full writes");
		end
		drain();
		finishTest("idle accesses", mark);

		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0 && testsFailed == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
src/modemPkg.sv
src/cordicPkg.sv
src/iqIf.sv
src/syncFifo.sv
src/qpskMapper.sv
src/cordicVectoring.sv
src/qpskSlicer.sv
src/modemTop.sv
test/modemTop_props.sv
test/tbModemTop.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = tbModemTop
RTL_TOP    = modemTop
FILELIST   = sim.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "Simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
